//--- logic/cpuPkg.sv
`default_nettype none

package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  regIndex_t;

    typedef enum logic [3:0] {
        aluOr     = 4'h0,
        aluAnd    = 4'h1,
        aluAdd    = 4'h2,
        aluMul    = 4'h3,
        aluRsv4   = 4'h4,
        aluShl    = 4'h5,
        aluLt     = 4'h6, // Comparisons give all ones when true
        aluEq     = 4'h7,
        aluGt     = 4'h8,
        aluAndNot = 4'h9,
        aluXor    = 4'ha,
        aluSub    = 4'hb,
        aluXnor   = 4'hc,
        aluShr    = 4'hd,
        aluNe     = 4'he,
        aluRsv15  = 4'hf
    } aluOp_e;

    typedef struct packed {
        logic      immType;  // Swap Y and immediate
        logic      storing;
        logic      derefRhs; // Right-hand side goes through memory
        regIndex_t z;
        regIndex_t x;
        regIndex_t y;
        aluOp_e    op;
        word_t     imm;      // Sign-extended from 12 bits
        logic      illegal;
        logic      branch;   // Writes the program counter
    } decodedInsn_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  strobe;
        logic  write;
    } memReq_t;

    localparam word_t insnNoop           = 32'h0000_0000; // r0 = r0 | r0, write dropped
    localparam word_t insnIllegal        = 32'hffff_ffff;
    localparam word_t resetVectorDefault = 32'h0000_0000;

endpackage

`default_nettype wire

//--- logic/insnDecode.sv
`timescale 1ns/1ps
`default_nettype none

module insnDecode (
    input  cpuPkg::word_t        insn,
    output cpuPkg::decodedInsn_t dec
);
    import cpuPkg::*;

    regIndex_t zField;

    assign zField = insn[27:24];

    always_comb begin
        dec.immType  = insn[30];
        dec.storing  = insn[29];
        dec.derefRhs = insn[28];
        dec.z        = zField;
        dec.x        = insn[23:20];
        dec.y        = insn[19:16];
        dec.op       = aluOp_e'(insn[15:12]);
        dec.imm      = {{20{insn[11]}}, insn[11:0]}; // Sign extend
        dec.illegal  = (insn == insnIllegal);
        dec.branch   = (zField == regIndex_t'(15)) && !insn[29]; // Only a store leaves pc alone
    end

endmodule

`default_nettype wire

//--- logic/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             writeEn,
    input  cpuPkg::regIndex_t indexX,
    input  cpuPkg::regIndex_t indexY,
    input  cpuPkg::regIndex_t indexZ,
    input  cpuPkg::word_t     writeData,
    input  cpuPkg::word_t     nextPc,
    output cpuPkg::word_t     valueX,
    output cpuPkg::word_t     valueY,
    output cpuPkg::word_t     valueZ
);
    import cpuPkg::*;

    word_t regs [1:14]; // r0 and r15 are aliases, not storage
    logic  zIsStored;

    assign zIsStored = (indexZ != '0) && (indexZ != '1);

    assign valueX = (indexX == '0) ? '0 : (indexX == '1) ? nextPc : regs[indexX];
    assign valueY = (indexY == '0) ? '0 : (indexY == '1) ? nextPc : regs[indexY];
    assign valueZ = (indexZ == '0) ? '0 : (indexZ == '1) ? nextPc : regs[indexZ];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 1; i <= 14; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && zIsStored) begin
            regs[indexZ] <= writeData; // Jumps through r15 are handled by the sequencer
        end
    end

endmodule

`default_nettype wire

//--- logic/aluExec.sv
`timescale 1ns/1ps
`default_nettype none

module aluExec (
    input  logic           clk,
    input  logic           en,
    input  cpuPkg::aluOp_e op,
    input  cpuPkg::word_t  opX,
    input  cpuPkg::word_t  opY,
    input  cpuPkg::word_t  addend,
    output cpuPkg::word_t  result
);
    import cpuPkg::*;

    word_t      opResult;
    logic [4:0] shamt;

    assign shamt = opY[4:0];

    always_comb begin
        case (op)
            aluOr:     opResult = opX | opY;
            aluAnd:    opResult = opX & opY;
            aluAdd:    opResult = opX + opY;
            aluMul:    opResult = opX * opY;       // Low word of the product
            aluShl:    opResult = opX << shamt;
            aluLt:     opResult = {32{$signed(opX) < $signed(opY)}};
            aluEq:     opResult = {32{opX == opY}};
            aluGt:     opResult = {32{$signed(opX) > $signed(opY)}};
            aluAndNot: opResult = opX & ~opY;
            aluXor:    opResult = opX ^ opY;
            aluSub:    opResult = opX - opY;
            aluXnor:   opResult = ~(opX ^ opY);
            aluShr:    opResult = opX >> shamt;    // Logical
            aluNe:     opResult = {32{opX != opY}};
            default:   opResult = '0;              // Reserved codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (en) begin
            result <= opResult + addend;
        end
    end

endmodule

`default_nettype wire

//--- logic/coreSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module coreSequencer #(
    parameter int unsigned   cyclesPerInsn = 8,
    parameter cpuPkg::word_t resetVector   = cpuPkg::resetVectorDefault
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            en,
    output cpuPkg::memReq_t insnReq,
    input  cpuPkg::word_t   insnData,
    output cpuPkg::memReq_t dataReq,
    input  cpuPkg::word_t   dataRead,
    output logic            halted
);
    import cpuPkg::*;

    localparam int unsigned q         = cyclesPerInsn / 4;
    localparam int unsigned lastPhase = cyclesPerInsn - 1;

    logic [cyclesPerInsn-1:0] phase;  // One-hot ring
    logic                     started;
    logic                     active;
    logic                     fetchEvt, aluEn, loadEvt, storeEvt, wbEvt;
    logic                     loading;
    word_t                    pc, nextPc, pcNext, insn;
    word_t                    valueX, valueY, valueZ;
    word_t                    rightOp, addend, aluResult, wbValue;
    decodedInsn_t             dec;

    // The word is captured on the edge before phase 0, so it sits in insn for the
    // whole instruction and the ALU result is ready by phase q
    assign active   = en && started && !halted;
    assign fetchEvt = en && !halted && (!started || phase[lastPhase]);
    assign aluEn    = active && phase[q-1];
    assign loadEvt  = active && phase[q];
    assign storeEvt = active && phase[2*q];
    assign wbEvt    = active && phase[3*q];

    assign loading = dec.derefRhs && !dec.storing;
    assign nextPc  = pc + 32'd1;
    assign wbValue = dec.derefRhs ? dataRead : aluResult; // Loaded word held by the memory
    assign pcNext  = dec.branch ? wbValue : nextPc;
    assign rightOp = dec.immType ? dec.imm : valueY;
    assign addend  = dec.immType ? valueY : dec.imm;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            phase   <= {{(cyclesPerInsn-1){1'b0}}, 1'b1};
            started <= 1'b0;
            pc      <= resetVector;
            insn    <= insnNoop;
            halted  <= 1'b0;
        end else if (en) begin
            started <= 1'b1;
            if (active) phase <= {phase[cyclesPerInsn-2:0], phase[lastPhase]};
            if (fetchEvt) insn <= insnData;
            if (loadEvt && dec.illegal) halted <= 1'b1; // Sticky until reset
            if (storeEvt) pc <= pcNext;
        end
    end

    // Next address goes out early so the word is back before the last phase
    always_comb begin
        insnReq.addr   = storeEvt ? pcNext : pc;
        insnReq.wdata  = '0;
        insnReq.strobe = 1'b1;
        insnReq.write  = 1'b0;
    end

    always_comb begin
        dataReq.addr   = dec.derefRhs ? aluResult : valueZ;
        dataReq.wdata  = dec.derefRhs ? valueZ : aluResult;
        dataReq.strobe = (loadEvt && loading) || (storeEvt && dec.storing);
        dataReq.write  = storeEvt && dec.storing;
    end

    insnDecode i_decode (
        .insn (insn),
        .dec  (dec)
    );

    regFile i_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .writeEn   (wbEvt && !dec.storing),
        .indexX    (dec.x),
        .indexY    (dec.y),
        .indexZ    (dec.z),
        .writeData (wbValue),
        .nextPc    (nextPc),
        .valueX    (valueX),
        .valueY    (valueY),
        .valueZ    (valueZ)
    );

    aluExec i_alu (
        .clk    (clk),
        .en     (aluEn),
        .op     (dec.op),
        .opX    (valueX),
        .opY    (rightOp),
        .addend (addend),
        .result (aluResult)
    );

endmodule

`default_nettype wire

//--- logic/wordMemory.sv
`timescale 1ns/1ps
`default_nettype none

module wordMemory #(
    parameter int unsigned addrBits = 8
) (
    input  logic            clk,
    input  cpuPkg::memReq_t req,
    output cpuPkg::word_t   rdata,
    input  logic            sideWrite,
    input  cpuPkg::word_t   sideAddr,
    input  cpuPkg::word_t   sideWdata,
    output cpuPkg::word_t   sideRdata
);
    import cpuPkg::*;

    word_t                mem [2**addrBits];
    logic  [addrBits-1:0] coreIdx;
    logic  [addrBits-1:0] sideIdx;

    assign coreIdx = req.addr[addrBits-1:0]; // Upper address bits ignored
    assign sideIdx = sideAddr[addrBits-1:0];

    always_ff @(posedge clk) begin
        if (req.strobe) begin
            if (req.write) mem[coreIdx] <= req.wdata;
            rdata <= mem[coreIdx]; // Held until the next strobe
        end
        if (sideWrite) begin
            mem[sideIdx] <= sideWdata; // Last assignment, so the side port wins
        end
        sideRdata <= mem[sideIdx];
    end

endmodule

`default_nettype wire

//--- logic/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop #(
    parameter int unsigned   cyclesPerInsn = 8,
    parameter int unsigned   addrBits      = 8,
    parameter cpuPkg::word_t resetVector   = cpuPkg::resetVectorDefault
) (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          en,
    input  logic          loadEn,
    input  cpuPkg::word_t loadAddr,
    input  cpuPkg::word_t loadData,
    input  cpuPkg::word_t peekAddr,
    output cpuPkg::word_t peekData,
    output logic          halted
);
    import cpuPkg::*;

    memReq_t insnReq, dataReq;
    word_t   insnData, dataRead;

    coreSequencer #(
        .cyclesPerInsn (cyclesPerInsn),
        .resetVector   (resetVector)
    ) i_core (
        .clk      (clk),
        .reset_n  (reset_n),
        .en       (en),
        .insnReq  (insnReq),
        .insnData (insnData),
        .dataReq  (dataReq),
        .dataRead (dataRead),
        .halted   (halted)
    );

    wordMemory #(.addrBits(addrBits)) i_progMem (
        .clk       (clk),
        .req       (insnReq),
        .rdata     (insnData),
        .sideWrite (loadEn),    // Program load
        .sideAddr  (loadAddr),
        .sideWdata (loadData),
        .sideRdata ()
    );

    wordMemory #(.addrBits(addrBits)) i_dataMem (
        .clk       (clk),
        .req       (dataReq),
        .rdata     (dataRead),
        .sideWrite (1'b0),      // Peek only
        .sideAddr  (peekAddr),
        .sideWdata ('0),
        .sideRdata (peekData)
    );

endmodule

`default_nettype wire

//--- bench/cpuTop_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop_checker (
    input logic clk,
    input logic reset_n,
    input logic dataStrobe,
    input logic dataWrite,
    input logic halted
);
    int unsigned failures = 0; // Summed into the bench verdict

    noStrobeWhenHalted: assert property (
        @(posedge clk) disable iff (!reset_n) halted |-> !dataStrobe
    ) else begin
        $error("data memory strobed while the core is halted");
        failures++;
    end

    // Synchronous reset, so a low reset_n at the edge is the only way out
    haltIsSticky: assert property (
        @(posedge clk) (halted && reset_n) |=> halted
    ) else begin
        $error("halted fell without a reset");
        failures++;
    end

    writeNeedsStrobe: assert property (
        @(posedge clk) dataWrite |-> dataStrobe
    ) else begin
        $error("data write raised without the strobe");
        failures++;
    end

endmodule

`default_nettype wire

//--- bench/cpuTop_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop_tb;
    import cpuPkg::*;

    typedef enum {ruleAlu, ruleSame, ruleZero, ruleCopy, ruleJump, ruleHalt, ruleStall} rule_e;

    typedef struct {
        string  name;
        aluOp_e op;
        bit     immType;
        rule_e  rule;
    } row_t;

    localparam int unsigned cyclesPerInsn = 8;
    localparam int numRows      = 25;
    localparam int maxProgLen   = 9;
    localparam int stallFrom    = 7;
    localparam int stallLen     = 12;
    localparam int rowCycles    = (maxProgLen + 2) * cyclesPerInsn + maxProgLen + 12;
    localparam int timeoutLimit = 10 + numRows * rowCycles + stallLen;
    localparam word_t allOnes   = 32'hffff_ffff;

    row_t rows [numRows] = '{
        '{"or", aluOr, 1'b0, ruleAlu},         '{"and", aluAnd, 1'b0, ruleAlu},
        '{"add", aluAdd, 1'b0, ruleAlu},       '{"mul", aluMul, 1'b0, ruleAlu},
        '{"rsv4", aluRsv4, 1'b0, ruleAlu},     '{"shl", aluShl, 1'b0, ruleAlu},
        '{"lt", aluLt, 1'b0, ruleAlu},         '{"eq", aluEq, 1'b0, ruleAlu},
        '{"gt", aluGt, 1'b0, ruleAlu},         '{"andNot", aluAndNot, 1'b0, ruleAlu},
        '{"xor", aluXor, 1'b0, ruleAlu},       '{"sub", aluSub, 1'b0, ruleAlu},
        '{"xnor", aluXnor, 1'b0, ruleAlu},     '{"shr", aluShr, 1'b0, ruleAlu},
        '{"ne", aluNe, 1'b0, ruleAlu},         '{"rsv15", aluRsv15, 1'b0, ruleAlu},
        '{"addSwap", aluAdd, 1'b1, ruleAlu},   '{"subSwap", aluSub, 1'b1, ruleAlu},
        '{"zeroReg", aluOr, 1'b0, ruleZero},   '{"loadCopy", aluOr, 1'b0, ruleCopy},
        '{"jump", aluOr, 1'b0, ruleJump},      '{"halt", aluOr, 1'b0, ruleHalt},
        '{"eqSame", aluEq, 1'b0, ruleSame},    '{"neSame", aluNe, 1'b0, ruleSame},
        '{"stall", aluAdd, 1'b0, ruleStall}
    };

    logic        clk, reset_n, en, loadEn, halted;
    word_t       loadAddr, loadData, peekAddr, peekData;
    word_t       prog [$];
    word_t       expA, expB, got, addrA, addrB;
    logic [11:0] a, b, c;
    logic [16:0] lfsr = 17'd79050;
    bit          checkB;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          expCycles, enCycles;

    bind coreSequencer cpuTop_checker i_checker (
        .clk        (clk),
        .reset_n    (reset_n),
        .dataStrobe (dataReq.strobe),
        .dataWrite  (dataReq.write),
        .halted     (halted)
    );

    cpuTop #(.cyclesPerInsn(cyclesPerInsn), .addrBits(8), .resetVector(32'h0)) i_cpuTop (
        .clk(clk), .reset_n(reset_n), .en(en), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .peekAddr(peekAddr), .peekData(peekData), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [16:0] lfsrNext(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]}; // x^17 + x^14 + 1
    endfunction

    task automatic rand12(output logic [11:0] v);
        v = '0;
        for (int i = 0; i < 12; i++) begin
            lfsr = lfsrNext(lfsr);
            v = {v[10:0], lfsr[0]};
        end
    endtask

    function automatic word_t sext(input logic [11:0] v);
        return word_t'($signed(v));
    endfunction

    function automatic word_t encode(input bit t, input bit st, input bit dr, input regIndex_t z,
                                     input regIndex_t x, input regIndex_t y, input aluOp_e op,
                                     input logic [11:0] imm);
        return {1'b0, t, st, dr, z, x, y, op, imm};
    endfunction

    function automatic word_t immToReg(input regIndex_t z, input logic [11:0] imm);
        return encode(1'b0, 1'b0, 1'b0, z, 4'd0, 4'd0, aluOr, imm);
    endfunction

    function automatic word_t storeImm(input regIndex_t addrReg, input logic [11:0] imm);
        return encode(1'b0, 1'b1, 1'b0, addrReg, 4'd0, 4'd0, aluOr, imm);
    endfunction

    function automatic word_t storeReg(input regIndex_t addrReg, input regIndex_t src);
        return encode(1'b0, 1'b1, 1'b0, addrReg, src, 4'd0, aluOr, 12'h000);
    endfunction

    function automatic word_t aluModel(input aluOp_e op, input word_t x, input word_t y);
        logic signed [31:0] sx, sy;
        sx = x;
        sy = y;
        case (op)
            aluOr:     return x | y;
            aluAnd:    return x & y;
            aluAdd:    return x + y;
            aluMul:    return x * y;
            aluShl:    return x << y[4:0];
            aluLt:     return (sx < sy) ? allOnes : '0;
            aluEq:     return (x == y) ? allOnes : '0;
            aluGt:     return (sx > sy) ? allOnes : '0;
            aluAndNot: return x & ~y;
            aluXor:    return x ^ y;
            aluSub:    return x - y;
            aluXnor:   return ~(x ^ y);
            aluShr:    return x >> y[4:0];
            aluNe:     return (x != y) ? allOnes : '0;
            default:   return '0;
        endcase
    endfunction

    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic peek(input word_t addr, output word_t value);
        @(posedge clk);
        #2;
        peekAddr = addr;
        @(posedge clk);
        @(negedge clk);
        value = peekData;
    endtask

    // Load under reset, release, then count enabled clocks up to the halt
    task automatic runProgram(input bit stall, output int enabled);
        int cyc;
        @(posedge clk);
        #2;
        reset_n = 1'b0;
        en      = 1'b1;
        foreach (prog[i]) begin
            @(posedge clk);
            #2;
            loadEn   = 1'b1;
            loadAddr = i;
            loadData = prog[i];
        end
        @(posedge clk);
        #2;
        loadEn = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        reset_n = 1'b1;
        cyc     = 0;
        enabled = 0;
        do begin
            @(posedge clk);
            if (en) enabled++;
            #2;
            cyc++;
            en = !(stall && cyc >= stallFrom && cyc < stallFrom + stallLen);
        end while (!halted);
        en = 1'b1;
    endtask

    initial begin
        while (cycles < timeoutLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run passed %0d cycles without finishing", timeoutLimit);
        $display("Errors found");
        $finish;
    end

    initial begin
        reset_n  = 1'b0;
        en       = 1'b1;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        peekAddr = '0;
        repeat (10) @(posedge clk);
        foreach (rows[r]) begin
            addrA  = 32'h40 + 2 * r; // Own result slots per row
            addrB  = addrA + 1;
            checkB = 1'b0;
            rand12(a);
            rand12(b);
            rand12(c);
            if (rows[r].rule == ruleSame) b = a; // Equal operands for the other compare outcome
            case (rows[r].rule)
                ruleZero: begin
                    prog = '{immToReg(4'd0, a | 12'h001), immToReg(4'd3, addrA[11:0]),
                             storeReg(4'd3, 4'd0), insnIllegal};
                    expA = '0;
                end
                ruleCopy: begin
                    prog = '{immToReg(4'd1, a), immToReg(4'd3, addrA[11:0]),
                             storeReg(4'd3, 4'd1),
                             encode(1'b0, 1'b0, 1'b1, 4'd4, 4'd0, 4'd0, aluOr, addrA[11:0]),
                             encode(1'b0, 1'b1, 1'b1, 4'd4, 4'd0, 4'd0, aluOr, addrB[11:0]),
                             insnIllegal};
                    expA   = sext(a);
                    expB   = sext(a);
                    checkB = 1'b1;
                end
                ruleJump: begin
                    prog = '{immToReg(4'd3, addrA[11:0]), immToReg(4'd1, a),
                             storeReg(4'd3, 4'd1), immToReg(4'd15, 12'd6),
                             storeImm(4'd3, ~a), insnIllegal, // Skipped by the jump
                             immToReg(4'd4, addrB[11:0]), storeImm(4'd4, c), insnIllegal};
                    expA   = sext(a);
                    expB   = sext(c);
                    checkB = 1'b1;
                end
                ruleHalt: begin
                    prog = '{immToReg(4'd3, addrA[11:0]), storeImm(4'd3, a), insnIllegal,
                             storeImm(4'd3, ~a), insnIllegal};
                    expA = sext(a);
                end
                default: begin
                    prog = '{immToReg(4'd1, a), immToReg(4'd2, b), immToReg(4'd3, addrA[11:0]),
                             encode(rows[r].immType, 1'b1, 1'b0, 4'd3, 4'd1, 4'd2,
                                    rows[r].op, c),
                             insnIllegal};
                    expA = rows[r].immType ? aluModel(rows[r].op, sext(a), sext(c)) + sext(b)
                                           : aluModel(rows[r].op, sext(a), sext(b)) + sext(c);
                end
            endcase
            runProgram(rows[r].rule == ruleStall, enCycles);
            peek(addrA, got);
            checkWord(rows[r].name, expA, got);
            if (checkB) begin
                peek(addrB, got);
                checkWord({rows[r].name, "/B"}, expB, got);
            end
            if (rows[r].rule == ruleStall) begin
                // First fetch edge, the words before the halt, then phase q of the halt
                expCycles = 2 + (prog.size() - 1) * cyclesPerInsn + cyclesPerInsn / 4;
                checkWord({rows[r].name, "/cycles"}, word_t'(expCycles), word_t'(enCycles));
            end
        end
        $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
                 checks, errors, i_cpuTop.i_core.i_checker.failures);
        if (errors == 0 && i_cpuTop.i_core.i_checker.failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
logic/cpuPkg.sv
logic/insnDecode.sv
logic/regFile.sv
logic/aluExec.sv
logic/coreSequencer.sv
logic/wordMemory.sv
logic/cpuTop.sv
bench/cpuTop_checker.sv
bench/cpuTop_tb.sv

//--- Bender.yml
package:
  name: cputop

sources:
  - files:
      - logic/cpuPkg.sv
      - logic/insnDecode.sv
      - logic/regFile.sv
      - logic/aluExec.sv
      - logic/coreSequencer.sv
      - logic/wordMemory.sv
      - logic/cpuTop.sv
  - target: test
    files:
      - bench/cpuTop_checker.sv
      - bench/cpuTop_tb.sv
